//--- verilog/rd_pkg.sv
`default_nettype none

package rd_pkg;

    // frame geometry, any size from 5x5 up
    localparam int COLS = 16;
    localparam int ROWS = 12;

    // 5x5 neighbourhood, centre at offset 2
    localparam int WIN = 5;
    localparam int CTR = WIN / 2;

    // one sampler per 45 degree step
    localparam int DIRS = 8;

    // unit step per direction, k*45 deg ccw from east
    // positive dy points up, toward lower row numbers
    localparam int DIR_DX [DIRS] = '{1, 1, 0, -1, -1, -1, 0, 1};
    localparam int DIR_DY [DIRS] = '{0, 1, 1, 1, 0, -1, -1, -1};

    // odd directions fall between grid points
    localparam int DIR_DIAG [DIRS] = '{0, 1, 0, 1, 0, 1, 0, 1};

    // raw intensity
    typedef logic [7:0] pixel_t;

    // four pixels summed, or one pixel scaled by four
    typedef logic [9:0] sample_t;

    // raster position
    typedef logic [$clog2(COLS)-1:0] col_t;
    typedef logic [$clog2(ROWS)-1:0] row_t;

    // bit k comes from direction k
    typedef logic [DIRS-1:0] code_t;

    // rotation-invariant uniform label, 0 to 9
    typedef logic [3:0] riu_t;

    // more than two transitions around the ring
    localparam riu_t RIU_NONUNIFORM = 4'd9;

    // px[row][col], offset 0 is the top-left pixel
    typedef struct packed {
        pixel_t [WIN-1:0][WIN-1:0] px;
    } window_t;

endpackage

`default_nettype wire

//--- verilog/window_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module window_buffer (
    input  logic            clk,
    input  logic            arst_n_i,
    input  rd_pkg::pixel_t  pixel_i,
    input  logic            pixel_stb_i,
    output rd_pkg::window_t win_o,
    output logic            win_stb_o,
    output logic            win_last_o
);

    import rd_pkg::*;

    // raster position of the incoming pixel
    col_t col_q;
    row_t row_q;

    // line memories, [0] is the row just above, [WIN-2] the oldest
    pixel_t row_mem [WIN-1][COLS];

    // column under the current pixel, [0] top row, [WIN-1] current row
    pixel_t [WIN-1:0] col_vec;

    // last five columns, [0] leftmost
    pixel_t [WIN-1:0] col_sh [WIN];

    logic interior;
    logic last_px;
    logic win_stb_q;
    logic win_last_q;

    // a window is complete once four rows and four columns lie behind
    assign interior = (row_q >= row_t'(WIN - 1)) && (col_q >= col_t'(WIN - 1));
    assign last_px  = (row_q == row_t'(ROWS - 1)) && (col_q == col_t'(COLS - 1));

    // stack the stored rows above the live pixel
    always_comb begin
        col_vec[WIN-1] = pixel_i;
        for (int k = 0; k < WIN - 1; k++) begin
            col_vec[WIN-2-k] = row_mem[k][col_q];
        end
    end

    // raster counters, wrap to (0, 0) after the last pixel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_stb_i) begin
            if (col_q == col_t'(COLS - 1)) begin
                col_q <= '0;
                if (row_q == row_t'(ROWS - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // each row memory passes its old pixel one row further up
    always_ff @(posedge clk) begin
        if (pixel_stb_i) begin
            row_mem[0][col_q] <= pixel_i;
            for (int k = 1; k < WIN - 1; k++) begin
                row_mem[k][col_q] <= row_mem[k-1][col_q];
            end
        end
    end

    // column shift, newest column enters on the right
    always_ff @(posedge clk) begin
        if (pixel_stb_i) begin
            for (int j = 0; j < WIN - 1; j++) begin
                col_sh[j] <= col_sh[j+1];
            end
            col_sh[WIN-1] <= col_vec;
        end
    end

    // window strobes, one cycle behind the completing pixel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            win_stb_q  <= 1'b0;
            win_last_q <= 1'b0;
        end else begin
            win_stb_q  <= pixel_stb_i && interior;
            win_last_q <= pixel_stb_i && last_px;
        end
    end

    // transpose columns into row-major window
    always_comb begin
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN; c++) begin
                win_o.px[r][c] = col_sh[c][r];
            end
        end
    end

    assign win_stb_o  = win_stb_q;
    assign win_last_o = win_last_q;

endmodule

`default_nettype wire

//--- verilog/ring_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module ring_sampler #(
    parameter int DIR = 0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  rd_pkg::window_t win_i,
    output logic            bit_o
);

    import rd_pkg::*;

    sample_t r1_sample;
    sample_t r2_sample;
    logic    bit_q;

    // sum over the four corners spanned by two ring points
    // an axial direction collapses them to one pixel counted four times
    function automatic sample_t ring_sample(window_t w, int r);
        int x0;
        int y0;
        int x1;
        int y1;
        sample_t acc;
        // outer corner at distance r along the direction
        x1 = r * DIR_DX[DIR];
        y1 = r * DIR_DY[DIR];
        // inner corner one step back on a diagonal
        x0 = (r - DIR_DIAG[DIR]) * DIR_DX[DIR];
        y0 = (r - DIR_DIAG[DIR]) * DIR_DY[DIR];
        // up means lower row index
        acc = sample_t'(w.px[CTR-y0][CTR+x0]);
        acc = acc + sample_t'(w.px[CTR-y0][CTR+x1]);
        acc = acc + sample_t'(w.px[CTR-y1][CTR+x0]);
        acc = acc + sample_t'(w.px[CTR-y1][CTR+x1]);
        return acc;
    endfunction

    // both samples at four times intensity scale
    always_comb begin
        r1_sample = ring_sample(win_i, 1);
        r2_sample = ring_sample(win_i, 2);
    end

    // radial difference, outer ring not darker than inner
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_q <= 1'b0;
        end else begin
            bit_q <= (r2_sample >= r1_sample);
        end
    end

    assign bit_o = bit_q;

endmodule

`default_nettype wire

//--- verilog/rd_code_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module rd_code_mapper (
    input  logic          clk,
    input  logic          arst_n_i,
    input  rd_pkg::code_t bits_i,
    input  logic          stb_i,
    input  logic          last_i,
    output rd_pkg::code_t code_o,
    output rd_pkg::riu_t  riu_o,
    output logic          code_stb_o,
    output logic          frame_end_o
);

    import rd_pkg::*;

    // neighbour pairs that differ, bit 7 wraps to bit 0
    code_t bit_edges;
    riu_t  label;

    // strobes lined up with the sampler bits
    logic stb_d;
    logic last_d;

    logic  code_stb_q;
    logic  frame_end_q;
    code_t code_q;
    riu_t  riu_q;

    assign bit_edges = bits_i ^ {bits_i[0], bits_i[DIRS-1:1]};

    // uniform patterns keep their ones count
    always_comb begin
        if ($countones(bit_edges) <= 2) begin
            label = riu_t'($countones(bits_i));
        end else begin
            label = RIU_NONUNIFORM;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stb_d       <= 1'b0;
            last_d      <= 1'b0;
            code_stb_q  <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            stb_d       <= stb_i;
            last_d      <= stb_i && last_i;
            code_stb_q  <= stb_d;
            frame_end_q <= last_d;
        end
    end

    // code and label hold between strobes
    always_ff @(posedge clk) begin
        if (stb_d) begin
            code_q <= bits_i;
            riu_q  <= label;
        end
    end

    assign code_o      = code_q;
    assign riu_o       = riu_q;
    assign code_stb_o  = code_stb_q;
    assign frame_end_o = frame_end_q;

endmodule

`default_nettype wire

//--- verilog/rd_descriptor_top.sv
`timescale 1ns/10ps
`default_nettype none

module rd_descriptor_top (
    input  logic           clk,
    input  logic           arst_n_i,
    input  rd_pkg::pixel_t pixel_i,
    input  logic           pixel_stb_i,
    output rd_pkg::code_t  code_o,
    output rd_pkg::riu_t   riu_o,
    output logic           code_stb_o,
    output logic           frame_end_o
);

    import rd_pkg::*;

    window_t win;
    logic    win_stb;
    logic    win_last;
    code_t   rd_bits;

    // 5x5 neighbourhood builder
    window_buffer u_window_buffer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pixel_i     (pixel_i),
        .pixel_stb_i (pixel_stb_i),
        .win_o       (win),
        .win_stb_o   (win_stb),
        .win_last_o  (win_last)
    );

    // one sampler per direction, bit k from direction k
    for (genvar k = 0; k < DIRS; k++) begin : g_dir
        ring_sampler #(
            .DIR (k)
        ) u_ring_sampler (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .win_i    (win),
            .bit_o    (rd_bits[k])
        );
    end

    // code packing and uniform label
    rd_code_mapper u_rd_code_mapper (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bits_i      (rd_bits),
        .stb_i       (win_stb),
        .last_i      (win_last),
        .code_o      (code_o),
        .riu_o       (riu_o),
        .code_stb_o  (code_stb_o),
        .frame_end_o (frame_end_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_rd_model.svh
`ifndef TB_RD_MODEL_SVH
`define TB_RD_MODEL_SVH

// the frame as it goes into the DUT, [row][col]
pixel_t ref_frame [ROWS][COLS];

// east/west part of the unit step, direction k at k*45 deg ccw from east
function automatic int step_x(int k);
    case (k % 8)
        0, 1, 7: return 1;
        3, 4, 5: return -1;
        default: return 0;
    endcase
endfunction

// north/south part, positive is up so the row index drops
function automatic int step_y(int k);
    case (k % 8)
        1, 2, 3: return 1;
        5, 6, 7: return -1;
        default: return 0;
    endcase
endfunction

function automatic int pix(int row, int col);
    return int'(ref_frame[row][col]);
endfunction

// one sample at radius r, always at four times intensity scale
function automatic int ring_value(int row, int col, int k, int r);
    int sx;
    int sy;
    int v;
    sx = step_x(k);
    sy = step_y(k);
    if (k % 2 == 0) begin
        // axial, the single pixel at distance r
        v = 4 * pix(row - r * sy, col + r * sx);
    end else if (r == 1) begin
        // centre, both axial neighbours and the corner
        v = pix(row, col) + pix(row, col + sx)
            + pix(row - sy, col) + pix(row - sy, col + sx);
    end else begin
        // offsets 1 and 2 on each axis, mirrored into the quadrant
        v = pix(row - sy, col + sx) + pix(row - sy, col + 2 * sx)
            + pix(row - 2 * sy, col + sx) + pix(row - 2 * sy, col + 2 * sx);
    end
    return v;
endfunction

// expected code for the window centred at (row, col)
function automatic code_t ref_code(int row, int col);
    code_t c;
    for (int k = 0; k < DIRS; k++) begin
        c[k] = (ring_value(row, col, k, 2) >= ring_value(row, col, k, 1));
    end
    return c;
endfunction

// ones count for at most two changes around the ring, else non-uniform
function automatic riu_t ref_label(code_t c);
    int changes;
    int ones;
    changes = 0;
    ones = 0;
    for (int k = 0; k < DIRS; k++) begin
        if (c[k] != c[(k + 1) % DIRS]) changes++;
        if (c[k]) ones++;
    end
    if (changes <= 2) begin
        return riu_t'(ones);
    end
    return RIU_NONUNIFORM;
endfunction

`endif

//--- tests/tb_rd_descriptor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rd_descriptor;

    import rd_pkg::*;

    `include "tb_rd_model.svh"

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    // codes in one frame, and complete frames in the run
    localparam int FRAME_CODES  = (ROWS - (WIN - 1)) * (COLS - (WIN - 1));
    localparam int FULL_FRAMES  = 8;
    // full frames plus the one cut short by reset
    localparam int WATCHDOG_NS  = (FULL_FRAMES + 1) * ROWS * COLS * 4 * CLK_PERIOD * 2;

    typedef enum {FILL_RANDOM, FILL_FLAT, FILL_RAMP, FILL_CHECKER} fill_e;

    // one expected output and the cycle it is due in
    typedef struct packed {
        code_t code;
        riu_t  riu;
        logic  last;
        int    due;
    } expect_t;

    logic   clk;
    logic   arst_n_i;
    pixel_t pixel_i;
    logic   pixel_stb_i;
    code_t  code_o;
    riu_t   riu_o;
    logic   code_stb_o;
    logic   frame_end_o;

    expect_t exp_q [$];
    integer  seed;
    int      cyc = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      codes_seen = 0;
    int      frame_codes = 0;
    int      frames_done = 0;

    rd_descriptor_top UUT (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pixel_i     (pixel_i),
        .pixel_stb_i (pixel_stb_i),
        .code_o      (code_o),
        .riu_o       (riu_o),
        .code_stb_o  (code_stb_o),
        .frame_end_o (frame_end_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_code(input code_t got, input code_t exp, input string name);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_riu(input riu_t got, input riu_t exp, input string name);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic fill_frame(input fill_e kind);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                case (kind)
                    FILL_RANDOM: ref_frame[r][c] = pixel_t'($random(seed));
                    FILL_FLAT:   ref_frame[r][c] = 8'h5a;
                    // brighter toward the east
                    FILL_RAMP:   ref_frame[r][c] = pixel_t'(c * (256 / COLS));
                    default:     ref_frame[r][c] = ((r + c) % 2 == 1) ? 8'hff : 8'h00;
                endcase
            end
        end
    endtask

    task automatic push_expect(input fill_e kind, input int row, input int col,
                               input logic last);
        expect_t e;
        if (kind == FILL_FLAT) begin
            // equal samples compare as not darker in every direction
            e.code = 8'hff;
            e.riu  = 4'd8;
        end else begin
            e.code = ref_code(row, col);
            e.riu  = ref_label(e.code);
        end
        e.last = last;
        // cyc still holds the previous edge here, strobe is 3 cycles out
        e.due = cyc + 4;
        exp_q.push_back(e);
    endtask

    // raster order, optional random idle cycles before each pixel
    task automatic send_frame(input fill_e kind, input bit gaps, input int rows);
        integer draw;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < COLS; c++) begin
                if (gaps) begin
                    draw = $random(seed);
                    while (draw[0]) begin
                        @(posedge clk);
                        pixel_stb_i <= 1'b0;
                        draw = $random(seed);
                    end
                end
                @(posedge clk);
                pixel_i     <= ref_frame[r][c];
                pixel_stb_i <= 1'b1;
                if (r >= WIN - 1 && c >= WIN - 1) begin
                    push_expect(kind, r - CTR, c - CTR, (r == ROWS - 1) && (c == COLS - 1));
                end
            end
        end
    endtask

    task automatic idle_until_drained();
        @(posedge clk);
        pixel_stb_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // room for a late or stray strobe
        repeat (4) @(posedge clk);
    endtask

    // pending codes die with the pipeline registers
    task automatic mid_reset();
        @(posedge clk);
        pixel_stb_i <= 1'b0;
        arst_n_i    <= 1'b0;
        exp_q.delete();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit(code_stb_o, 1'b0, "code_stb_o");
            check_bit(frame_end_o, 1'b0, "frame_end_o");
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
    endtask

    // scoreboard, sampled at the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (!arst_n_i) frame_codes = 0;
        if (code_stb_o === 1'b1) begin
            codes_seen++;
            frame_codes++;
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("t=%0t code strobe with no completed window behind it", $time);
            end else begin
                e = exp_q.pop_front();
                if (e.due != cyc) begin
                    protocol_errors++;
                    $display("t=%0t code strobe in cycle %0d, expected in cycle %0d",
                             $time, cyc, e.due);
                end
                check_code(code_o, e.code, "code_o");
                check_riu(riu_o, e.riu, "riu_o");
                check_bit(frame_end_o, e.last, "frame_end_o");
            end
            if (frame_end_o === 1'b1) begin
                frames_done++;
                if (frame_codes != FRAME_CODES) begin
                    protocol_errors++;
                    $display("t=%0t frame ended after %0d codes instead of %0d",
                             $time, frame_codes, FRAME_CODES);
                end
                frame_codes = 0;
            end
        end else begin
            if (frame_end_o === 1'b1) begin
                protocol_errors++;
                $display("t=%0t frame end pulse without a code strobe", $time);
            end
            if (exp_q.size() != 0 && exp_q[0].due < cyc) begin
                protocol_errors++;
                $display("t=%0t code due in cycle %0d never came", $time, exp_q[0].due);
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        seed        = 32'h0e8f_4897;
        arst_n_i    = 1'b0;
        pixel_i     = '0;
        pixel_stb_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        // two random frames back to back
        fill_frame(FILL_RANDOM);
        send_frame(FILL_RANDOM, 1'b0, ROWS);
        fill_frame(FILL_RANDOM);
        send_frame(FILL_RANDOM, 1'b0, ROWS);
        fill_frame(FILL_FLAT);
        send_frame(FILL_FLAT, 1'b0, ROWS);
        // same frame without and then with gaps
        fill_frame(FILL_RANDOM);
        send_frame(FILL_RANDOM, 1'b0, ROWS);
        send_frame(FILL_RANDOM, 1'b1, ROWS);
        fill_frame(FILL_RAMP);
        send_frame(FILL_RAMP, 1'b0, ROWS);
        fill_frame(FILL_CHECKER);
        send_frame(FILL_CHECKER, 1'b0, ROWS);
        // cut a frame short, then a clean one
        fill_frame(FILL_RANDOM);
        send_frame(FILL_RANDOM, 1'b0, ROWS / 2 + 1);
        mid_reset();
        fill_frame(FILL_RANDOM);
        send_frame(FILL_RANDOM, 1'b1, ROWS);
        idle_until_drained();
        if (frames_done != FULL_FRAMES) begin
            protocol_errors++;
            $display("%0d frame end pulses seen instead of %0d", frames_done, FULL_FRAMES);
        end
        $display("errors: %0d wrong values, %0d protocol, %0d codes checked",
                 value_errors, protocol_errors, codes_seen);
        if (value_errors + protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+tests
verilog/rd_pkg.sv
verilog/window_buffer.sv
verilog/ring_sampler.sv
verilog/rd_code_mapper.sv
verilog/rd_descriptor_top.sv
tests/tb_rd_descriptor.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_rd_descriptor
RTL_TOP    := rd_descriptor_top
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
